// ==== itim.sv ====
module itim (
  input  logic               clk,
  input  logic               rst,
  input  itim_pkg::mem_req_t fetch_req,
  output itim_pkg::mem_rsp_t fetch_rsp,
  output itim_pkg::mem_req_t imem_req,
  input  itim_pkg::mem_rsp_t imem_rsp
);

  import itim_pkg::*;

  logic [IDX_W-1:0] rd_idx;
  line_rd_t         rd_line;
  line_wr_t         wr;
  logic             take;
  logic             idle;
  decoded_t         dec;
  resp_sel_t        sel;

  itim_array i_array (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rd_line (rd_line),
    .wr      (wr)
  );

  itim_decode i_decode (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .idle      (idle),
    .rd_idx    (rd_idx),
    .rd_line   (rd_line),
    .take      (take),
    .dec       (dec)
  );

  itim_execute i_execute (
    .clk      (clk),
    .rst      (rst),
    .take     (take),
    .dec      (dec),
    .idle     (idle),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .wr       (wr),
    .sel      (sel)
  );

  // Line data follows the held index, so it is valid when the answer is formed
  itim_result i_result (
    .clk       (clk),
    .rst       (rst),
    .sel       (sel),
    .line_data (rd_line.data),
    .fetch_rsp (fetch_rsp)
  );

endmodule

// ==== itim_array.sv ====
module itim_array (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [itim_pkg::IDX_W-1:0]  rd_idx,
  output itim_pkg::line_rd_t          rd_line,
  input  itim_pkg::line_wr_t          wr
);

  import itim_pkg::*;

  logic [TAG_W-1:0]  tag_mem  [0:LINES-1];
  logic [LINE_W-1:0] data_mem [0:LINES-1];
  logic [LINES-1:0]  lock_mem;

  // Combinational read port
  always_comb begin
    rd_line.tag  = tag_mem[rd_idx];
    rd_line.data = data_mem[rd_idx];
    rd_line.lock = lock_mem[rd_idx];
  end

  // Tag and data change only on a fill and not on a lock clear
  always_ff @(posedge clk) begin
    if (wr.wen && wr.lock) begin
      tag_mem[wr.idx]  <= wr.tag;
      data_mem[wr.idx] <= wr.data;
    end
  end

  // Lock bits double as the line valid flags
  always_ff @(posedge clk) begin
    if (!rst) begin
      lock_mem <= '0;
    end else if (wr.wen) begin
      lock_mem[wr.idx] <= wr.lock;
    end
  end

endmodule

// ==== itim_decode.sv ====
`include "itim_params.svh"

module itim_decode (
  input  logic                        clk,
  input  logic                        rst,
  input  itim_pkg::mem_req_t          fetch_req,
  input  logic                        idle,
  output logic [itim_pkg::IDX_W-1:0]  rd_idx,
  input  itim_pkg::line_rd_t          rd_line,
  output logic                        take,
  output itim_pkg::decoded_t          dec
);

  import itim_pkg::*;

  logic        capture;
  logic [31:0] addr_q;
  logic        fence_q;
  logic        in_window;
  logic        tag_match;

  // The controller reports idle in the take cycle too, so block a second capture
  assign capture = idle && fetch_req.valid && !take;

  always_ff @(posedge clk) begin
    if (!rst) begin
      take <= 1'b0;
    end else begin
      take <= capture;
    end
  end

  // Held request stays stable until the next capture
  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q  <= fetch_req.addr;
      fence_q <= fetch_req.fence;
    end
  end

  // Address split
  always_comb begin
    dec.addr = addr_q;
    dec.tag  = addr_q[31 -: TAG_W];
    dec.idx  = addr_q[WID_W+2 +: IDX_W];
    dec.wid  = addr_q[2 +: WID_W];
  end

  assign rd_idx = dec.idx;

  assign in_window = (addr_q >= `ITIM_BASE_ADDR) && (addr_q < `ITIM_TOP_ADDR);
  assign tag_match = (rd_line.tag == dec.tag);

  // Priority order is fence, window, lock, then tag
  always_comb begin
    if (fence_q) begin
      dec.cls = CLS_FENCE;
    end else if (!in_window) begin
      dec.cls = CLS_BYPASS;
    end else if (!rd_line.lock) begin
      dec.cls = CLS_MISS;
    end else if (!tag_match) begin
      // Locked line owned by another address stays in place
      dec.cls = CLS_BYPASS;
    end else begin
      dec.cls = CLS_HIT;
    end
  end

endmodule

// ==== itim_execute.sv ====
module itim_execute (
  input  logic                clk,
  input  logic                rst,
  input  logic                take,
  input  itim_pkg::decoded_t  dec,
  output logic                idle,
  output itim_pkg::mem_req_t  imem_req,
  input  itim_pkg::mem_rsp_t  imem_rsp,
  output itim_pkg::line_wr_t  wr,
  output itim_pkg::resp_sel_t sel
);

  import itim_pkg::*;

  itim_state_e       state;
  logic [WID_W-1:0]  cnt;
  logic [IDX_W-1:0]  inv_idx;
  logic [LINE_W-1:0] fill_buf;
  logic [LINE_W-1:0] fill_data;
  logic              resp_pend;
  logic              last_word;
  logic              last_line;

  assign last_word = (cnt == WID_W'(WORDS - 1));
  assign last_line = (inv_idx == IDX_W'(LINES - 1));

  // No new fetch while the response is still on its way out
  assign idle = (state == ST_IDLE) && !resp_pend;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      inv_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (take) begin
            case (dec.cls)
              CLS_HIT: state <= ST_DONE;
              CLS_MISS: begin
                state <= ST_FILL;
                cnt   <= '0;
              end
              CLS_BYPASS: state <= ST_BYPASS;
              default: begin
                state   <= ST_INV;
                inv_idx <= '0;
              end
            endcase
          end
        end
        ST_FILL: begin
          if (imem_rsp.ready) begin
            if (last_word) begin
              state <= ST_DONE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        ST_BYPASS: begin
          if (imem_rsp.ready) begin
            state <= ST_IDLE;
          end
        end
        ST_INV: begin
          if (last_line) begin
            state <= ST_DONE;
          end else begin
            inv_idx <= inv_idx + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      resp_pend <= 1'b0;
    end else begin
      resp_pend <= sel.ready;
    end
  end

  // Fill buffer with the arriving word merged in
  always_comb begin
    fill_data = fill_buf;
    fill_data[cnt*32 +: 32] = imem_rsp.rdata;
  end

  always_ff @(posedge clk) begin
    if (state == ST_FILL && imem_rsp.ready) begin
      fill_buf <= fill_data;
    end
  end

  // Words of a line are fetched in order starting at word 0
  always_comb begin
    imem_req.valid = (state == ST_FILL) || (state == ST_BYPASS);
    imem_req.fence = 1'b0;
    if (state == ST_FILL) begin
      imem_req.addr = {dec.addr[31:WID_W+2], cnt, 2'b00};
    end else begin
      imem_req.addr = dec.addr;
    end
  end

  always_comb begin
    wr.wen  = (state == ST_INV) || (state == ST_FILL && imem_rsp.ready && last_word);
    wr.idx  = (state == ST_INV) ? inv_idx : dec.idx;
    wr.tag  = dec.tag;
    wr.data = fill_data;
    wr.lock = (state == ST_FILL);
  end

  // A fence answers through the memory path with a zero word
  always_comb begin
    sel.ready    = (state == ST_DONE) || (state == ST_BYPASS && imem_rsp.ready);
    sel.from_mem = (state == ST_BYPASS) || (dec.cls == CLS_FENCE);
    sel.wid      = dec.wid;
    sel.mem_word = (state == ST_BYPASS) ? imem_rsp.rdata : 32'h0;
  end

endmodule

// ==== itim_mem_model.sv ====
module itim_mem_model #(
  parameter logic [31:0] SEED = 32'h87e516b8
) (
  input  logic               clk,
  input  logic               rst,
  input  itim_pkg::mem_req_t imem_req,
  input  logic [31:0]        word,
  output itim_pkg::mem_rsp_t imem_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] lcg;
  logic        busy;
  int          wait_left;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Outputs change 1 ns after the rising edge
  initial begin
    imem_rsp  = '0;
    busy      = 1'b0;
    wait_left = 0;
    lcg       = SEED;
    forever begin
      @(posedge clk);
      #1;
      if (!rst) begin
        imem_rsp = '0;
        busy     = 1'b0;
      end else begin
        // Ready seen at this edge retired the request
        if (imem_rsp.ready) begin
          imem_rsp.ready = 1'b0;
          busy           = 1'b0;
        end
        if (!busy && imem_req.valid) begin
          lcg       = lcg_next(lcg);
          wait_left = int'(lcg[17:16]);
          busy      = 1'b1;
        end
        if (busy && !imem_rsp.ready) begin
          if (wait_left == 0) begin
            imem_rsp.ready = 1'b1;
            imem_rsp.rdata = word;
          end else begin
            wait_left--;
          end
        end
      end
    end
  end

endmodule

// ==== itim_params.svh ====
`ifndef ITIM_PARAMS_SVH
`define ITIM_PARAMS_SVH

// Line store geometry

// Index bits, giving 2**ITIM_DEPTH lines
`define ITIM_DEPTH 4

// Word-select bits, giving 2**ITIM_WIDTH words per line
`define ITIM_WIDTH 2

// Address window served from the line store

// First address inside the window
`define ITIM_BASE_ADDR 32'h0000_1000

// First address past the window
`define ITIM_TOP_ADDR 32'h0000_2000

// Fetches outside the window always go to instruction memory
// and never allocate a line

`endif

// ==== itim_pkg.sv ====
`include "itim_params.svh"

package itim_pkg;

  // Geometry derived from the macros
  localparam int IDX_W  = `ITIM_DEPTH;
  localparam int WID_W  = `ITIM_WIDTH;
  localparam int LINES  = 2 ** IDX_W;
  localparam int WORDS  = 2 ** WID_W;
  localparam int LINE_W = WORDS * 32;
  // Address bits left after index, word select and byte offset
  localparam int TAG_W  = 32 - IDX_W - WID_W - 2;

  // Request used on the fetch side and toward instruction memory
  typedef struct packed {
    logic        valid;
    logic        fence;
    logic [31:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // One line as read from the store
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [LINE_W-1:0] data;
    logic              lock;
  } line_rd_t;

  // One store write for a fill or a lock clear
  typedef struct packed {
    logic              wen;
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [LINE_W-1:0] data;
    logic              lock;
  } line_wr_t;

  typedef enum logic [1:0] {
    CLS_HIT,
    CLS_MISS,
    CLS_BYPASS,
    CLS_FENCE
  } req_class_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FILL,
    ST_BYPASS,
    ST_INV,
    ST_DONE
  } itim_state_e;

  typedef struct packed {
    req_class_e       cls;
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [WID_W-1:0] wid;
    logic [31:0]      addr;
  } decoded_t;

  // Response selection handed to the output stage
  typedef struct packed {
    logic             ready;
    logic             from_mem;
    logic [WID_W-1:0] wid;
    logic [31:0]      mem_word;
  } resp_sel_t;

endpackage

// ==== itim_result.sv ====
module itim_result (
  input  logic                         clk,
  input  logic                         rst,
  input  itim_pkg::resp_sel_t          sel,
  input  logic [itim_pkg::LINE_W-1:0]  line_data,
  output itim_pkg::mem_rsp_t           fetch_rsp
);

  import itim_pkg::*;

  logic [31:0] word;
  logic        ready_q;
  logic [31:0] rdata_q;

  // Word from the line, or the word handed over by the controller
  always_comb begin
    if (sel.from_mem) begin
      word = sel.mem_word;
    end else begin
      word = line_data[sel.wid*32 +: 32];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel.ready;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= word;
  end

  assign fetch_rsp.ready = ready_q;
  assign fetch_rsp.rdata = rdata_q;

endmodule

// ==== itim_tb.sv ====
`include "itim_params.svh"

module itim_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import itim_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int N_TESTS         = 5;
  localparam int REQS_PER_TEST   = 200;
  localparam int WATCHDOG_CYCLES = N_TESTS * REQS_PER_TEST * 40;
  localparam logic [31:0] LINE_A = 32'h0000_1230;

  logic        clk;
  logic        rst;
  mem_req_t    fetch_req;
  mem_rsp_t    fetch_rsp;
  mem_req_t    imem_req;
  mem_rsp_t    imem_rsp;
  logic [31:0] imem_word;
  logic [31:0] exp_q[$];
  int          errors = 0;
  int          checks = 0;
  int          imem_count = 0;

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [31:0] expected_rdata(input mem_req_t req);
    return req.fence ? 32'h0 : mem_word(req.addr);
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int mark);
    $display("test %s: %0d errors", name, errors - mark);
  endtask

  // Runs one fetch and returns the imem transactions it caused and its latency in edges
  task automatic run_fetch(input logic [31:0] addr, input logic fence,
                           output int n_imem, output int edges);
    int start;
    start = imem_count;
    @(posedge clk);
    #1;
    fetch_req.valid = 1'b1;
    fetch_req.fence = fence;
    fetch_req.addr  = addr;
    exp_q.push_back(expected_rdata(fetch_req));
    edges = 0;
    @(negedge clk);
    while (!fetch_rsp.ready) begin
      @(negedge clk);
      edges++;
    end
    @(posedge clk);
    #1;
    fetch_req = '0;
    n_imem = imem_count - start;
  endtask

  itim i_itim (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .imem_req  (imem_req),
    .imem_rsp  (imem_rsp)
  );

  assign imem_word = mem_word(imem_req.addr);

  itim_mem_model i_mem (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .word     (imem_word),
    .imem_rsp (imem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Compare every response with the oldest outstanding fetch
  always @(negedge clk) begin
    if (fetch_rsp.ready) begin
      assert (exp_q.size() != 0) else begin
        $display("Error at %0t ns: response without an outstanding fetch", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        check_value("fetch_rsp.rdata", fetch_rsp.rdata, exp_q.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (imem_req.valid) begin
      check_value("imem_req.fence", imem_req.fence, 1'b0);
    end
    if (imem_req.valid && imem_rsp.ready) begin
      imem_count++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    int               n_imem;
    int               edges;
    int               mark;
    int               exp_n;
    logic [31:0]      rnd;
    logic [31:0]      addr;
    logic             fence;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             lock_sh [LINES];
    logic [TAG_W-1:0] tag_sh [LINES];
    rst = 1'b0;
    fetch_req = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;

    mark = errors;
    run_fetch(LINE_A + 4, 1'b0, n_imem, edges);
    check_value("imem requests", n_imem, WORDS);
    for (int w = 0; w < WORDS; w++) begin
      if (w != 1) begin
        run_fetch(LINE_A + 4 * w, 1'b0, n_imem, edges);
        check_value("imem requests", n_imem, 0);
        // One edge to take the fetch, two more to the response
        check_value("hit latency", edges, 3);
      end
    end
    report_test("cold miss and hits", mark);

    mark = errors;
    repeat (3) begin
      run_fetch(32'h0000_0800, 1'b0, n_imem, edges);
      check_value("imem requests", n_imem, 1);
    end
    report_test("bypass outside window", mark);

    mark = errors;
    run_fetch(LINE_A + 32'h100, 1'b0, n_imem, edges);
    check_value("imem requests", n_imem, 1);
    run_fetch(LINE_A, 1'b0, n_imem, edges);
    check_value("imem requests", n_imem, 0);
    report_test("tag conflict", mark);

    mark = errors;
    run_fetch(32'h0, 1'b1, n_imem, edges);
    check_value("imem requests", n_imem, 0);
    run_fetch(LINE_A + 8, 1'b0, n_imem, edges);
    check_value("imem requests", n_imem, WORDS);
    report_test("fence", mark);

    // Start from an empty store so the shadow matches
    mark = errors;
    run_fetch(32'h0, 1'b1, n_imem, edges);
    for (int i = 0; i < LINES; i++) begin
      lock_sh[i] = 1'b0;
      tag_sh[i]  = '0;
    end
    rnd = 32'h87e516b8;
    repeat (REQS_PER_TEST) begin
      rnd   = lcg_next(rnd);
      fence = (rnd[31:28] == 4'd0);
      if (rnd[31:28] < 4'd4) begin
        addr = 32'h0000_4000 + {20'b0, rnd[11:2], 2'b00};
      end else begin
        addr = `ITIM_BASE_ADDR + {22'b0, rnd[25:24], rnd[19:16], rnd[11:10], 2'b00};
      end
      idx = addr[WID_W+2 +: IDX_W];
      tag = addr[31 -: TAG_W];
      if (fence) begin
        exp_n = 0;
        for (int i = 0; i < LINES; i++) begin
          lock_sh[i] = 1'b0;
        end
      end else if (addr < `ITIM_BASE_ADDR || addr >= `ITIM_TOP_ADDR) begin
        exp_n = 1;
      end else if (!lock_sh[idx]) begin
        exp_n = WORDS;
        lock_sh[idx] = 1'b1;
        tag_sh[idx]  = tag;
      end else begin
        exp_n = (tag_sh[idx] != tag) ? 1 : 0;
      end
      run_fetch(addr, fence, n_imem, edges);
      check_value("imem requests", n_imem, exp_n);
    end
    report_test("random stream", mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
itim_pkg.sv
itim_array.sv
itim_decode.sv
itim_execute.sv
itim_result.sv
itim.sv
itim_mem_model.sv
itim_tb.sv
